//--- verilog/div_pkg.sv
`default_nettype none

package div_pkg;

  localparam int VLEN    = 128;
  localparam int VLENB   = VLEN / 8;
  localparam int BYTE_W  = 8;
  localparam int HWORD_W = 16;
  localparam int WORD_W  = 32;
  localparam int XLEN    = 32;
  localparam int ROB_W   = 4;

  // low half on byte lanes, upper bytes spill onto the wider lanes
  localparam int LANES8  = VLENB / 2;
  localparam int LANES16 = VLEN / HWORD_W / 2;
  localparam int LANES32 = VLEN / WORD_W;

  typedef logic [VLEN-1:0]  vreg_t;
  typedef logic [XLEN-1:0]  xreg_t;
  typedef logic [ROB_W-1:0] rob_entry_t;
  typedef logic [5:0]       funct6_t;
  typedef logic [2:0]       funct3_t;

  localparam funct3_t OPMVV = 3'b010;
  localparam funct3_t OPMVX = 3'b110;

  localparam funct6_t FUNCT_VDIVU = 6'b100000;
  localparam funct6_t FUNCT_VDIV  = 6'b100001;
  localparam funct6_t FUNCT_VREMU = 6'b100010;
  localparam funct6_t FUNCT_VREM  = 6'b100011;

  typedef enum logic [1:0] {
    EEW8,
    EEW16,
    EEW32
  } eew_e;

  typedef enum logic {
    DIV_UNSIGNED,
    DIV_SIGNED
  } lane_sign_e;

endpackage

`default_nettype wire

//--- verilog/div_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

// operands spread onto the divider lanes
interface lane_in_if import div_pkg::*; ();
  logic                              start;
  lane_sign_e                        sign;
  logic                              en8;
  logic                              en16;
  logic                              en32;
  logic [LANES8-1:0][BYTE_W-1:0]     src2_8;
  logic [LANES8-1:0][BYTE_W-1:0]     src1_8;
  logic [LANES16-1:0][HWORD_W-1:0]   src2_16;
  logic [LANES16-1:0][HWORD_W-1:0]   src1_16;
  logic [LANES32-1:0][WORD_W-1:0]    src2_32;
  logic [LANES32-1:0][WORD_W-1:0]    src1_32;

  modport decode (output start, sign, en8, en16, en32,
                  output src2_8, src1_8, src2_16, src1_16, src2_32, src1_32);
  modport execute (input start, sign, en8, en16, en32,
                   input src2_8, src1_8, src2_16, src1_16, src2_32, src1_32);
endinterface

// per-lane results, done once every started group has finished
interface lane_out_if import div_pkg::*; ();
  logic [LANES8-1:0][BYTE_W-1:0]     quot8;
  logic [LANES8-1:0][BYTE_W-1:0]     rem8;
  logic [LANES16-1:0][HWORD_W-1:0]   quot16;
  logic [LANES16-1:0][HWORD_W-1:0]   rem16;
  logic [LANES32-1:0][WORD_W-1:0]    quot32;
  logic [LANES32-1:0][WORD_W-1:0]    rem32;
  logic                              done;

  modport execute (output quot8, rem8, quot16, rem16, quot32, rem32, done);
  modport result (input quot8, rem8, quot16, rem16, quot32, rem32, done);
endinterface

`default_nettype wire

//--- verilog/div_decode.sv
`timescale 1ns/1ps
`default_nettype none

module div_decode import div_pkg::*; (
  input  logic      div_uop_valid,
  input  funct6_t   funct6,
  input  funct3_t   funct3,
  input  vreg_t     vs1_data,
  input  logic      vs1_data_valid,
  input  vreg_t     vs2_data,
  input  logic      vs2_data_valid,
  input  eew_e      eew,
  input  xreg_t     rs1_data,
  input  logic      rs1_data_valid,
  lane_in_if.decode lanes
);

  logic  is_div;
  logic  ops_ok;
  logic  sgn;
  vreg_t src1_vec;

  // element idx of v at width e, extended to a word
  function automatic logic [WORD_W-1:0] elem(input vreg_t v, input int idx,
                                             input eew_e e, input logic s);
    logic [WORD_W-1:0] r;
    case (e)
      EEW8:    r = {{(WORD_W-BYTE_W){s & v[idx*BYTE_W+BYTE_W-1]}}, v[idx*BYTE_W +: BYTE_W]};
      EEW16:   r = {{(WORD_W-HWORD_W){s & v[idx*HWORD_W+HWORD_W-1]}},
                    v[idx*HWORD_W +: HWORD_W]};
      default: r = v[idx*WORD_W +: WORD_W];
    endcase
    return r;
  endfunction

  assign is_div = funct6 inside {FUNCT_VDIVU, FUNCT_VDIV, FUNCT_VREMU, FUNCT_VREM};
  assign ops_ok = (funct3 == OPMVV) ? (vs2_data_valid && vs1_data_valid) :
                  (funct3 == OPMVX) ? (vs2_data_valid && rs1_data_valid) : 1'b0;
  assign sgn    = (funct6 == FUNCT_VDIV) || (funct6 == FUNCT_VREM);

  assign lanes.start = div_uop_valid && is_div && ops_ok;
  assign lanes.sign  = sgn ? DIV_SIGNED : DIV_UNSIGNED;
  assign lanes.en8   = (eew == EEW8);
  assign lanes.en16  = (eew != EEW32);
  assign lanes.en32  = 1'b1;

  // scalar divisor broadcast at element width
  always_comb begin
    src1_vec = vs1_data;
    if (funct3 == OPMVX) begin
      case (eew)
        EEW8:    src1_vec = {VLENB{rs1_data[BYTE_W-1:0]}};
        EEW16:   src1_vec = {(VLEN/HWORD_W){rs1_data[HWORD_W-1:0]}};
        default: src1_vec = {(VLEN/WORD_W){rs1_data[WORD_W-1:0]}};
      endcase
    end
  end

  always_comb begin
    logic [WORD_W-1:0] e2;
    logic [WORD_W-1:0] e1;
    int                base16;
    int                base32;
    e2 = '0;
    e1 = '0;
    base16 = (eew == EEW8) ? LANES8 : 0;
    base32 = (eew == EEW8) ? LANES8 + LANES16 : (eew == EEW16) ? LANES16 : 0;
    lanes.src2_8  = '0;
    lanes.src1_8  = '0;
    lanes.src2_16 = '0;
    lanes.src1_16 = '0;
    for (int i = 0; i < LANES8; i++) begin
      if (eew == EEW8) begin
        e2 = elem(vs2_data, i, eew, sgn);
        e1 = elem(src1_vec, i, eew, sgn);
        lanes.src2_8[i] = e2[BYTE_W-1:0];
        lanes.src1_8[i] = e1[BYTE_W-1:0];
      end
    end
    for (int i = 0; i < LANES16; i++) begin
      if (eew != EEW32) begin
        e2 = elem(vs2_data, base16 + i, eew, sgn);
        e1 = elem(src1_vec, base16 + i, eew, sgn);
        lanes.src2_16[i] = e2[HWORD_W-1:0];
        lanes.src1_16[i] = e1[HWORD_W-1:0];
      end
    end
    // word lanes take whatever is left at the top
    for (int i = 0; i < LANES32; i++) begin
      lanes.src2_32[i] = elem(vs2_data, base32 + i, eew, sgn);
      lanes.src1_32[i] = elem(src1_vec, base32 + i, eew, sgn);
    end
  end

endmodule

`default_nettype wire

//--- verilog/div_divider.sv
`timescale 1ns/1ps
`default_nettype none

module div_divider import div_pkg::*; #(
  parameter int DIV_WIDTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  lane_sign_e           sign,
  input  logic [DIV_WIDTH-1:0] dividend,
  input  logic [DIV_WIDTH-1:0] divisor,
  input  logic                 release_req,
  output logic [DIV_WIDTH-1:0] quotient,
  output logic [DIV_WIDTH-1:0] remainder,
  output logic                 done
);

  typedef enum logic [1:0] {IDLE, RUN, HOLD} state_e;
  typedef logic [$clog2(DIV_WIDTH+1)-1:0] cnt_t;

  state_e               state_q;
  cnt_t                 cnt_q;
  logic [DIV_WIDTH-1:0] quo_q;
  logic [DIV_WIDTH-1:0] rem_q;
  logic [DIV_WIDTH-1:0] dvs_q;
  logic                 quo_neg_q;
  logic                 rem_neg_q;
  logic                 dvd_neg;
  logic                 dvs_neg;
  logic [DIV_WIDTH-1:0] dvd_mag;
  logic [DIV_WIDTH-1:0] dvs_mag;
  logic                 zero_div;
  logic                 overflow;
  logic [DIV_WIDTH:0]   rem_shift;
  logic [DIV_WIDTH:0]   trial;
  logic                 last;

  assign dvd_neg   = (sign == DIV_SIGNED) && dividend[DIV_WIDTH-1];
  assign dvs_neg   = (sign == DIV_SIGNED) && divisor[DIV_WIDTH-1];
  assign dvd_mag   = dvd_neg ? -dividend : dividend;
  assign dvs_mag   = dvs_neg ? -divisor : divisor;
  assign zero_div  = (divisor == '0);
  // most negative / -1
  assign overflow  = (sign == DIV_SIGNED) && (divisor == '1) &&
                     (dividend == {1'b1, {(DIV_WIDTH-1){1'b0}}});
  assign rem_shift = {rem_q, quo_q[DIV_WIDTH-1]};
  assign trial     = rem_shift - {1'b0, dvs_q};
  assign last      = (cnt_q == cnt_t'(DIV_WIDTH));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start) begin
            cnt_q   <= '0;
            state_q <= (zero_div || overflow) ? HOLD : RUN;
          end
        end
        RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (last) begin
            state_q <= HOLD;
          end
        end
        HOLD: begin
          if (release_req) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && start) begin
      dvs_q     <= dvs_mag;
      quo_neg_q <= dvd_neg ^ dvs_neg;
      rem_neg_q <= dvd_neg;
      if (zero_div) begin
        quo_q <= '1;
        rem_q <= dividend;
      end else if (overflow) begin
        quo_q <= dividend;
        rem_q <= '0;
      end else begin
        quo_q <= dvd_mag;
        rem_q <= '0;
      end
    end else if (state_q == RUN) begin
      if (last) begin
        // sign fixup on the way to HOLD
        quo_q <= quo_neg_q ? -quo_q : quo_q;
        rem_q <= rem_neg_q ? -rem_q : rem_q;
      end else if (!trial[DIV_WIDTH]) begin
        rem_q <= trial[DIV_WIDTH-1:0];
        quo_q <= {quo_q[DIV_WIDTH-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[DIV_WIDTH-1:0];
        quo_q <= {quo_q[DIV_WIDTH-2:0], 1'b0};
      end
    end
  end

  assign quotient  = quo_q;
  assign remainder = rem_q;
  assign done      = (state_q == HOLD);

endmodule

`default_nettype wire

//--- verilog/div_execute.sv
`timescale 1ns/1ps
`default_nettype none

module div_execute import div_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        result_ready,
  lane_in_if.execute  lanes,
  lane_out_if.execute results
);

  logic [LANES8-1:0]  done8;
  logic [LANES16-1:0] done16;
  logic [LANES32-1:0] done32;
  logic               active_q;
  logic               grp8_q;
  logic               grp16_q;
  logic               grp32_q;
  logic               all_done;
  logic               release_req;

  // only groups that were started count towards done
  assign all_done    = active_q && (!grp8_q || &done8) && (!grp16_q || &done16) &&
                       (!grp32_q || &done32);
  assign release_req = all_done && result_ready;
  assign results.done = all_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      grp8_q   <= 1'b0;
      grp16_q  <= 1'b0;
      grp32_q  <= 1'b0;
    end else if (release_req) begin
      active_q <= 1'b0;
    end else if (!active_q && lanes.start) begin
      active_q <= 1'b1;
      grp8_q   <= lanes.en8;
      grp16_q  <= lanes.en16;
      grp32_q  <= lanes.en32;
    end
  end

  for (genvar j = 0; j < LANES8; j++) begin : g_div8
    div_divider #(.DIV_WIDTH(BYTE_W)) u_div (
      .clk, .rst_n, .start(lanes.start && lanes.en8), .sign(lanes.sign),
      .dividend(lanes.src2_8[j]), .divisor(lanes.src1_8[j]), .release_req,
      .quotient(results.quot8[j]), .remainder(results.rem8[j]), .done(done8[j])
    );
  end

  for (genvar j = 0; j < LANES16; j++) begin : g_div16
    div_divider #(.DIV_WIDTH(HWORD_W)) u_div (
      .clk, .rst_n, .start(lanes.start && lanes.en16), .sign(lanes.sign),
      .dividend(lanes.src2_16[j]), .divisor(lanes.src1_16[j]), .release_req,
      .quotient(results.quot16[j]), .remainder(results.rem16[j]), .done(done16[j])
    );
  end

  for (genvar j = 0; j < LANES32; j++) begin : g_div32
    div_divider #(.DIV_WIDTH(WORD_W)) u_div (
      .clk, .rst_n, .start(lanes.start && lanes.en32), .sign(lanes.sign),
      .dividend(lanes.src2_32[j]), .divisor(lanes.src1_32[j]), .release_req,
      .quotient(results.quot32[j]), .remainder(results.rem32[j]), .done(done32[j])
    );
  end

endmodule

`default_nettype wire

//--- verilog/div_result.sv
`timescale 1ns/1ps
`default_nettype none

module div_result import div_pkg::*; (
  input  funct6_t           funct6,
  input  eew_e              eew,
  lane_out_if.result        results,
  output vreg_t             w_data
);

  logic                            use_rem;
  logic [LANES8-1:0][BYTE_W-1:0]   r8;
  logic [LANES16-1:0][HWORD_W-1:0] r16;
  logic [LANES32-1:0][WORD_W-1:0]  r32;

  assign use_rem = (funct6 == FUNCT_VREMU) || (funct6 == FUNCT_VREM);
  assign r8      = use_rem ? results.rem8 : results.quot8;
  assign r16     = use_rem ? results.rem16 : results.quot16;
  assign r32     = use_rem ? results.rem32 : results.quot32;

  // same lane split as decode, low bits of the wider lanes
  always_comb begin
    w_data = '0;
    case (eew)
      EEW8: begin
        for (int i = 0; i < LANES8; i++) begin
          w_data[i*BYTE_W +: BYTE_W] = r8[i];
        end
        for (int i = 0; i < LANES16; i++) begin
          w_data[(LANES8+i)*BYTE_W +: BYTE_W] = r16[i][BYTE_W-1:0];
        end
        for (int i = 0; i < LANES32; i++) begin
          w_data[(LANES8+LANES16+i)*BYTE_W +: BYTE_W] = r32[i][BYTE_W-1:0];
        end
      end
      EEW16: begin
        for (int i = 0; i < LANES16; i++) begin
          w_data[i*HWORD_W +: HWORD_W] = r16[i];
        end
        for (int i = 0; i < LANES32; i++) begin
          w_data[(LANES16+i)*HWORD_W +: HWORD_W] = r32[i][HWORD_W-1:0];
        end
      end
      default: begin
        for (int i = 0; i < LANES32; i++) begin
          w_data[i*WORD_W +: WORD_W] = r32[i];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit import div_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       div_uop_valid,
  input  rob_entry_t rob_entry,
  input  funct6_t    funct6,
  input  funct3_t    funct3,
  input  vreg_t      vs1_data,
  input  logic       vs1_data_valid,
  input  vreg_t      vs2_data,
  input  logic       vs2_data_valid,
  input  eew_e       eew,
  input  xreg_t      rs1_data,
  input  logic       rs1_data_valid,
  input  logic       result_ready,
  output logic       result_valid,
  output rob_entry_t result_rob_entry,
  output vreg_t      result_w_data
);

  lane_in_if  lane_in ();
  lane_out_if lane_out ();

  div_decode u_decode (
    .div_uop_valid  (div_uop_valid),
    .funct6         (funct6),
    .funct3         (funct3),
    .vs1_data       (vs1_data),
    .vs1_data_valid (vs1_data_valid),
    .vs2_data       (vs2_data),
    .vs2_data_valid (vs2_data_valid),
    .eew            (eew),
    .rs1_data       (rs1_data),
    .rs1_data_valid (rs1_data_valid),
    .lanes          (lane_in.decode)
  );

  div_execute u_execute (
    .clk            (clk),
    .rst_n          (rst_n),
    .result_ready   (result_ready),
    .lanes          (lane_in.execute),
    .results        (lane_out.execute)
  );

  div_result u_result (
    .funct6         (funct6),
    .eew            (eew),
    .results        (lane_out.result),
    .w_data         (result_w_data)
  );

  // uop fields are held until accepted, so the tag passes straight through
  assign result_valid     = lane_out.done;
  assign result_rob_entry = rob_entry;

endmodule

`default_nettype wire

//--- test/tb_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit import div_pkg::*; ();

  localparam int NUM_UOPS   = 34;
  localparam int IDLE_WAIT  = 100;
  localparam int MAX_CYCLES = NUM_UOPS * 200 + 15;

  logic       clk;
  logic       rst_n;
  logic       div_uop_valid;
  rob_entry_t rob_entry;
  funct6_t    funct6;
  funct3_t    funct3;
  vreg_t      vs1_data;
  logic       vs1_data_valid;
  vreg_t      vs2_data;
  logic       vs2_data_valid;
  eew_e       eew;
  xreg_t      rs1_data;
  logic       rs1_data_valid;
  logic       result_ready;
  logic       result_valid;
  rob_entry_t result_rob_entry;
  vreg_t      result_w_data;

  logic [31:0] lfsr = 32'h3f5a_4f0e;
  vreg_t       exp_data_q[$];
  rob_entry_t  exp_rob_q[$];
  rob_entry_t  rob_next = '0;
  int          errors = 0;
  int          results = 0;
  int          sent = 0;
  int          cycles = 0;
  logic        held = 1'b0;
  vreg_t       held_data;
  rob_entry_t  held_rob;
  vreg_t       exp_d;
  rob_entry_t  exp_r;

  div_unit u_div_unit (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr stepped once per bit
  function logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'hD000_0001;
    return b;
  endfunction

  function vreg_t rand_vec(input int n);
    vreg_t v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[VLEN-2:0], next_bit()};
    return v;
  endfunction

  function automatic vreg_t set_elem(input vreg_t v, input int idx, input int w,
                                     input logic [31:0] val);
    vreg_t m;
    m = ((vreg_t'(1) << w) - 1) << (idx * w);
    return (v & ~m) | ((vreg_t'(val) << (idx * w)) & m);
  endfunction

  // one element by the riscv divide rules
  function automatic logic [31:0] ref_elem(input logic [31:0] a, input logic [31:0] b,
                                           input int w, input logic sgn, input logic rem);
    logic [31:0] m;
    logic [31:0] ua;
    logic [31:0] ub;
    logic [31:0] q;
    logic [31:0] r;
    longint      sa;
    longint      sb;
    m = (w == 32) ? 32'hFFFF_FFFF : (32'h1 << w) - 32'h1;
    ua = a & m;
    ub = b & m;
    sa = {32'h0, ua};
    sb = {32'h0, ub};
    if (sgn && ua[w-1]) sa = sa - (longint'(1) << w);
    if (sgn && ub[w-1]) sb = sb - (longint'(1) << w);
    if (ub == 0) begin
      q = m;
      r = ua;
    end else if (sgn && sa == -(longint'(1) << (w - 1)) && sb == -1) begin
      q = ua;
      r = '0;
    end else if (sgn) begin
      q = 32'(sa / sb);
      r = 32'(sa % sb);
    end else begin
      q = ua / ub;
      r = ua % ub;
    end
    return (rem ? r : q) & m;
  endfunction

  function automatic vreg_t ref_vec(input funct6_t f6, input funct3_t f3, input eew_e e,
                                    input vreg_t a_v, input vreg_t b_v, input xreg_t s);
    vreg_t       res;
    vreg_t       ta;
    vreg_t       tb;
    int          w;
    logic        sgn;
    logic        rem;
    logic [31:0] r;
    w = (e == EEW8) ? 8 : (e == EEW16) ? 16 : 32;
    sgn = (f6 == FUNCT_VDIV) || (f6 == FUNCT_VREM);
    rem = (f6 == FUNCT_VREMU) || (f6 == FUNCT_VREM);
    res = '0;
    for (int i = 0; i < VLEN / w; i++) begin
      ta = a_v >> (i * w);
      tb = b_v >> (i * w);
      r = ref_elem(ta[31:0], (f3 == OPMVX) ? s : tb[31:0], w, sgn, rem);
      res = res | (vreg_t'(r) << (i * w));
    end
    return res;
  endfunction

  // holds the uop until it is accepted, or for a fixed window if none is due
  task automatic send_uop(input funct6_t f6, input funct3_t f3, input eew_e e, input vreg_t a,
                          input vreg_t b, input xreg_t s, input logic v2_ok, input logic v1_ok,
                          input logic x_ok, input logic want);
    @(posedge clk);
    div_uop_valid  <= 1'b1;
    rob_entry      <= rob_next;
    funct6         <= f6;
    funct3         <= f3;
    eew            <= e;
    vs2_data       <= a;
    vs2_data_valid <= v2_ok;
    vs1_data       <= b;
    vs1_data_valid <= v1_ok;
    rs1_data       <= s;
    rs1_data_valid <= x_ok;
    result_ready   <= next_bit();
    if (want) begin
      exp_data_q.push_back(ref_vec(f6, f3, e, a, b, s));
      exp_rob_q.push_back(rob_next);
      sent++;
      @(negedge clk);
      while (!(result_valid && result_ready)) begin
        @(posedge clk);
        result_ready <= next_bit();
        @(negedge clk);
      end
    end else begin
      repeat (IDLE_WAIT) begin
        @(posedge clk);
        result_ready <= next_bit();
      end
    end
    rob_next = rob_next + 1'b1;
  endtask

  // checker on the falling edge
  initial begin
    forever begin
      @(negedge clk);
      if (held) begin
        assert (result_valid) else begin
          $display("result_valid dropped at %0t while result_ready was low", $time);
          errors++;
        end
        assert (result_w_data === held_data) else begin
          $display("ERROR %0t result_w_data got %h held %h", $time, result_w_data, held_data);
          errors++;
        end
        assert (result_rob_entry === held_rob) else begin
          $display("ERROR %0t result_rob_entry got %h held %h", $time, result_rob_entry,
                   held_rob);
          errors++;
        end
      end
      if (result_valid) begin
        assert (exp_data_q.size() > 0) else begin
          $display("result_valid high at %0t with no uop outstanding", $time);
          errors++;
        end
      end
      if (result_valid && result_ready && exp_data_q.size() > 0) begin
        exp_d = exp_data_q.pop_front();
        exp_r = exp_rob_q.pop_front();
        results++;
        assert (result_w_data === exp_d) else begin
          $display("ERROR %0t result_w_data got %h expected %h", $time, result_w_data, exp_d);
          errors++;
        end
        assert (result_rob_entry === exp_r) else begin
          $display("ERROR %0t result_rob_entry got %h expected %h", $time, result_rob_entry,
                   exp_r);
          errors++;
        end
      end
      held = result_valid && !result_ready;
      held_data = result_w_data;
      held_rob = result_rob_entry;
    end
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles: %0d errors, %0d of %0d results seen", cycles, errors,
             results, sent);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    vreg_t a;
    vreg_t b;
    xreg_t s;
    int    w;
    int    n;
    rst_n = 1'b0;
    div_uop_valid = 1'b0;
    rob_entry = '0;
    funct6 = '0;
    funct3 = '0;
    eew = EEW8;
    vs1_data = '0;
    vs1_data_valid = 1'b0;
    vs2_data = '0;
    vs2_data_valid = 1'b0;
    rs1_data = '0;
    rs1_data_valid = 1'b0;
    result_ready = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // vector-vector ops with overflow and zero divisors planted on the second pass
    for (int rep = 0; rep < 2; rep++) begin
      for (int e = 0; e < 3; e++) begin
        for (int k = 0; k < 4; k++) begin
          w = 8 << e;
          n = VLEN / w;
          a = rand_vec(VLEN);
          b = rand_vec(VLEN);
          if (rep == 1) begin
            a = set_elem(a, 0, w, 32'h1 << (w - 1));
            b = set_elem(b, 0, w, 32'hFFFF_FFFF);
            a = set_elem(a, n - 1, w, 32'h1 << (w - 1));
            b = set_elem(b, n - 1, w, 32'hFFFF_FFFF);
            b = set_elem(b, 1, w, 32'h0);
            b = set_elem(b, n - 2, w, 32'h0);
          end
          send_uop(funct6_t'(FUNCT_VDIVU + k), OPMVV, eew_e'(e), a, b, '0,
                   1'b1, 1'b1, 1'b1, 1'b1);
        end
      end
    end

    // scalar divisor where the upper bits of rs1 are ignored
    for (int e = 0; e < 3; e++) begin
      for (int k = 0; k < 4; k += 3) begin
        a = rand_vec(VLEN);
        b = rand_vec(VLEN);
        s = xreg_t'(rand_vec(XLEN));
        send_uop(funct6_t'(FUNCT_VDIVU + k), OPMVX, eew_e'(e), a, b, s,
                 1'b1, 1'b0, 1'b1, 1'b1);
      end
    end

    // none of these may start
    send_uop(6'b100100, OPMVV, EEW32, a, b, s, 1'b1, 1'b1, 1'b1, 1'b0);
    send_uop(FUNCT_VDIV, OPMVV, EEW16, a, b, s, 1'b1, 1'b0, 1'b1, 1'b0);
    send_uop(FUNCT_VREMU, OPMVX, EEW8, a, b, s, 1'b1, 1'b1, 1'b0, 1'b0);
    send_uop(FUNCT_VDIVU, OPMVX, EEW8, a, b, s, 1'b0, 1'b1, 1'b1, 1'b0);

    @(posedge clk);
    div_uop_valid <= 1'b0;
    repeat (4) @(posedge clk);
    $display("errors: %0d, results: %0d of %0d", errors, results, sent);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/div_pkg.sv
verilog/div_lane_if.sv
verilog/div_decode.sv
verilog/div_divider.sv
verilog/div_execute.sv
verilog/div_result.sv
verilog/div_unit.sv
test/tb_div_unit.sv

//--- Bender.yml
package:
  name: div_unit

sources:
  - verilog/div_pkg.sv
  - verilog/div_lane_if.sv
  - verilog/div_decode.sv
  - verilog/div_divider.sv
  - verilog/div_execute.sv
  - verilog/div_result.sv
  - verilog/div_unit.sv
  - target: test
    files:
      - test/tb_div_unit.sv
